// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := asi_tb
FILELIST  := list.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== list.f ====
+incdir+test
src/asi_crypto_pkg.sv
src/asi_isa_pkg.sv
src/asi_ctrl.sv
src/asi_sha256.sv
src/asi_sha3.sv
src/asi_aessub.sv
src/asi_aesmix.sv
src/asi_top.sv
test/asi_tb.sv

// ==== src/asi_aesmix.sv ====
`default_nettype none

module asi_aesmix
    import asi_crypto_pkg::*;
(
    input  wire   word_t rs1,
    input  wire   word_t rs2,
    input  wire   enc,                          // MixColumns when set
    output word_t result
);

    // First row of each circulant matrix
    localparam byte_t MIX_FWD [4] = '{8'h02, 8'h03, 8'h01, 8'h01};
    localparam byte_t MIX_INV [4] = '{8'h0e, 8'h0b, 8'h0d, 8'h09};

    byte_t col   [4];                           // Input column
    byte_t coef  [4];                           // Active matrix row
    byte_t mixed [4];                           // Output column

    // Low half from rs1, high half from rs2
    assign col[0] = rs1[7:0];
    assign col[1] = rs1[15:8];
    assign col[2] = rs2[23:16];
    assign col[3] = rs2[31:24];

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            coef[i] = enc ? MIX_FWD[i] : MIX_INV[i];
        end
        // Row i uses the coefficients rotated right by i
        for (int i = 0; i < 4; i++) begin
            mixed[i] = '0;
            for (int j = 0; j < 4; j++) begin
                mixed[i] ^= gf_mul(coef[(j - i) & 3], col[j]);
            end
        end
    end

    assign result = {mixed[3], mixed[2], mixed[1], mixed[0]};

endmodule

`default_nettype wire

// ==== src/asi_aessub.sv ====
`default_nettype none

module asi_aessub
    import asi_crypto_pkg::*;
    import asi_isa_pkg::*;
(
    input  wire   g_clk,
    input  wire   rst_n,
    input  wire   valid,                        // Held until ready
    input  wire   word_t rs1,
    input  wire   word_t rs2,
    input  wire   enc,                          // Forward S-box when set
    input  wire   rot,                          // Rotate result left by 8
    output logic  ready,
    output word_t result
);

    logic [1:0]  cnt;                           // Byte being substituted
    logic [23:0] partial;                       // Bytes already done
    logic        last;
    word_t       src;
    byte_t       b_in;
    byte_t       b_out;
    word_t       word;

    // Byte selection ------------------------

    // Even bytes from rs1, odd bytes from rs2
    assign src  = cnt[0] ? rs2 : rs1;
    assign b_in = src[{cnt, 3'b000} +: 8];

    // The single shared S-box
    assign b_out = enc ? sbox_fwd(b_in) : sbox_inv(b_in);

    assign last  = cnt == 2'(AESSUB_CYCLES - 1);
    assign ready = valid && last;

    // Top byte completes the word in the same cycle
    assign word   = {b_out, partial};
    assign result = rot ? {word[23:0], word[31:24]} : word;

    // Byte sequencer ------------------------

    always_ff @(posedge g_clk) begin
        if (!rst_n || !valid || last) begin
            cnt     <= '0;                      // Ready for the next instruction
            partial <= '0;
        end else begin
            cnt     <= cnt + 2'd1;
            partial[{cnt, 3'b000} +: 8] <= b_out; // Bytes 0..2 only
        end
    end

endmodule

`default_nettype wire

// ==== src/asi_crypto_pkg.sv ====
`default_nettype none

package asi_crypto_pkg;

    localparam int XLEN = 32;                   // Register width

    typedef logic [XLEN-1:0] word_t;            // One register value
    typedef logic [7:0]      byte_t;            // One AES state byte

    // GF(2^8) arithmetic ------------

    // Multiply by x, reduced modulo 0x11b
    function automatic byte_t xtime(byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // Shift-and-add multiply
    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t p;
        byte_t m;
        p = '0;
        m = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p ^= m;                         // Add this power of x
            end
            m = xtime(m);
        end
        return p;
    endfunction

    // Field inverse as a^254, zero maps to zero
    function automatic byte_t gf_inv(byte_t a);
        byte_t p;
        byte_t r;
        p = a;
        r = 8'h01;
        for (int i = 1; i < 8; i++) begin
            p = gf_mul(p, p);                   // a^(2^i)
            r = gf_mul(r, p);
        end
        return r;
    endfunction

    function automatic byte_t rotl(byte_t b, int n);
        return (b << n) | (b >> (8 - n));
    endfunction

    // S-box ------------

    // Inverse then affine map
    function automatic byte_t sbox_fwd(byte_t a);
        byte_t i;
        i = gf_inv(a);
        return i ^ rotl(i, 1) ^ rotl(i, 2) ^ rotl(i, 3) ^ rotl(i, 4) ^ 8'h63;
    endfunction

    // Inverse affine map first, then field inverse
    function automatic byte_t sbox_inv(byte_t a);
        byte_t t;
        t = rotl(a, 1) ^ rotl(a, 3) ^ rotl(a, 6) ^ 8'h05;
        return gf_inv(t);
    endfunction

endpackage

`default_nettype wire

// ==== src/asi_ctrl.sv ====
`default_nettype none

module asi_ctrl
    import asi_crypto_pkg::*;
    import asi_isa_pkg::*;
(
    input  wire        valid,                   // Request held until ready
    input  wire        asi_req_t req,
    input  wire        sub_ready,               // SubBytes unit done
    input  wire        word_t res_sha2,
    input  wire        word_t res_sha3,
    input  wire        word_t res_sub,
    input  wire        word_t res_mix,
    output word_t      sha2_rs1,
    output logic [1:0] sha2_ss,
    output asi_req_t   sha3_req,
    output logic       sub_valid,
    output word_t      sub_rs1,
    output word_t      sub_rs2,
    output logic       sub_enc,
    output logic       sub_rot,
    output word_t      mix_rs1,
    output word_t      mix_rs2,
    output logic       mix_enc,
    output logic       ready,
    output word_t      result
);

    logic insn_sha2;
    logic insn_sha3;
    logic insn_sub;
    logic insn_mix;

    // Decode ------------------------

    // Exact matches only, unused functions select nothing
    assign insn_sha2 = valid && (req.uop == ASI_SHA256_S0 || req.uop == ASI_SHA256_S1 ||
                                 req.uop == ASI_SHA256_S2 || req.uop == ASI_SHA256_S3);
    assign insn_sha3 = valid && (req.uop == ASI_SHA3_XY || req.uop == ASI_SHA3_X1 ||
                                 req.uop == ASI_SHA3_X2 || req.uop == ASI_SHA3_X4 ||
                                 req.uop == ASI_SHA3_YX);
    assign insn_sub  = valid && (req.uop == ASI_AESSUB_ENC || req.uop == ASI_AESSUB_ENCROT ||
                                 req.uop == ASI_AESSUB_DEC || req.uop == ASI_AESSUB_DECROT);
    assign insn_mix  = valid && (req.uop == ASI_AESMIX_ENC || req.uop == ASI_AESMIX_DEC);

    // Operand gating ------------------------

    // Idle units see zeros so their logic does not toggle
    assign sha2_rs1  = {XLEN{insn_sha2}} & req.rs1;
    assign sha2_ss   = req.uop[1:0];             // S0..S3

    assign sha3_req  = insn_sha3 ? req : '0;     // Zero uop keeps SHA-3 unit idle

    assign sub_valid = insn_sub;                 // Starts the byte counter
    assign sub_rs1   = {XLEN{insn_sub}} & req.rs1;
    assign sub_rs2   = {XLEN{insn_sub}} & req.rs2;
    assign sub_enc   = !req.uop[0];
    assign sub_rot   = req.uop[1];

    assign mix_rs1   = {XLEN{insn_mix}} & req.rs1;
    assign mix_rs2   = {XLEN{insn_mix}} & req.rs2;
    assign mix_enc   = !req.uop[0];

    // Ready and result ------------------------

    // Only SubBytes takes more than one cycle
    assign ready = insn_sha2 || insn_sha3 || insn_mix || (insn_sub && sub_ready);

    assign result = ({XLEN{insn_sha2}} & res_sha2) |
                    ({XLEN{insn_sha3}} & res_sha3) |
                    ({XLEN{insn_sub}}  & res_sub)  |
                    ({XLEN{insn_mix}}  & res_mix);

endmodule

`default_nettype wire

// ==== src/asi_isa_pkg.sv ====
`default_nettype none

package asi_isa_pkg;

    import asi_crypto_pkg::*;

    // Class lives in uop[4:3], class 3 is unused
    localparam logic [1:0] ASI_CLS_SHA2 = 2'd0;
    localparam logic [1:0] ASI_CLS_SHA3 = 2'd1;
    localparam logic [1:0] ASI_CLS_AES  = 2'd2;

    typedef logic [4:0] uop_t;                  // {class, function}

    // Micro-op encodings ------------

    localparam uop_t ASI_SHA256_S0 = {ASI_CLS_SHA2, 3'd0};
    localparam uop_t ASI_SHA256_S1 = {ASI_CLS_SHA2, 3'd1};
    localparam uop_t ASI_SHA256_S2 = {ASI_CLS_SHA2, 3'd2};
    localparam uop_t ASI_SHA256_S3 = {ASI_CLS_SHA2, 3'd3};

    localparam uop_t ASI_SHA3_XY   = {ASI_CLS_SHA3, 3'd0};
    localparam uop_t ASI_SHA3_X1   = {ASI_CLS_SHA3, 3'd1};
    localparam uop_t ASI_SHA3_X2   = {ASI_CLS_SHA3, 3'd2};
    localparam uop_t ASI_SHA3_X4   = {ASI_CLS_SHA3, 3'd3};
    localparam uop_t ASI_SHA3_YX   = {ASI_CLS_SHA3, 3'd4};

    // Bit 0 set is decrypt, bit 1 set is rotate
    localparam uop_t ASI_AESSUB_ENC    = {ASI_CLS_AES, 3'd0};
    localparam uop_t ASI_AESSUB_DEC    = {ASI_CLS_AES, 3'd1};
    localparam uop_t ASI_AESSUB_ENCROT = {ASI_CLS_AES, 3'd2};
    localparam uop_t ASI_AESSUB_DECROT = {ASI_CLS_AES, 3'd3};

    // Bit 2 set selects the mix unit
    localparam uop_t ASI_AESMIX_ENC    = {ASI_CLS_AES, 3'd4};
    localparam uop_t ASI_AESMIX_DEC    = {ASI_CLS_AES, 3'd5};

    localparam int AESSUB_CYCLES = 4;          // One S-box pass per byte

    // Request as seen on the unit boundary
    typedef struct packed {
        uop_t       uop;                        // Operation
        word_t      rs1;                        // Source register 1
        word_t      rs2;                        // Source register 2
        logic [1:0] shamt;                      // SHA-3 post-shift
    } asi_req_t;

endpackage

`default_nettype wire

// ==== src/asi_sha256.sv ====
`default_nettype none

module asi_sha256
    import asi_crypto_pkg::*;
(
    input  wire        word_t rs1,
    input  wire  [1:0] ss,                      // Which sigma
    output word_t      result
);

    // Rotate right by a constant
    function automatic word_t ror(word_t x, int n);
        return (x >> n) | (x << (XLEN - n));
    endfunction

    always_comb begin
        unique case (ss)
            2'd0:    result = ror(rs1, 7)  ^ ror(rs1, 18) ^ (rs1 >> 3);   // Small sigma 0
            2'd1:    result = ror(rs1, 17) ^ ror(rs1, 19) ^ (rs1 >> 10);  // Small sigma 1
            2'd2:    result = ror(rs1, 2)  ^ ror(rs1, 13) ^ ror(rs1, 22); // Big sigma 0
            default: result = ror(rs1, 6)  ^ ror(rs1, 11) ^ ror(rs1, 25); // Big sigma 1
        endcase
    end

endmodule

`default_nettype wire

// ==== src/asi_sha3.sv ====
`default_nettype none

module asi_sha3
    import asi_crypto_pkg::*;
    import asi_isa_pkg::*;
(
    input  wire   asi_req_t req,
    output word_t result
);

    logic [2:0] x;                              // Lane column
    logic [2:0] y;                              // Lane row
    logic [4:0] y5;                             // 5y, at most 20
    logic [2:0] yx_row;
    logic [4:0] idx;                            // Lane index 0..24

    // Coordinates reduced from the full registers
    assign x  = 3'(req.rs1 % XLEN'(5));
    assign y  = 3'(req.rs2 % XLEN'(5));
    assign y5 = 5'(y) * 5'd5;

    // (2x + 3y) mod 5, at most 20 before reduction
    assign yx_row = 3'((5'(x) * 5'd2 + 5'(y) * 5'd3) % 5'd5);

    always_comb begin
        case (req.uop)                          // Full uop, so class is checked too
            ASI_SHA3_XY: idx = 5'(x) + y5;
            ASI_SHA3_X1: idx = ((5'(x) + 5'd1) % 5'd5) + y5;
            ASI_SHA3_X2: idx = ((5'(x) + 5'd2) % 5'd5) + y5;
            ASI_SHA3_X4: idx = ((5'(x) + 5'd4) % 5'd5) + y5;
            ASI_SHA3_YX: idx = 5'(y) + 5'(yx_row) * 5'd5;
            default:     idx = '0;              // Not a SHA-3 op
        endcase
    end

    // Byte offset into the state, hence the post-shift
    assign result = word_t'(idx) << req.shamt;

endmodule

`default_nettype wire

// ==== src/asi_top.sv ====
`default_nettype none

module asi_top
    import asi_crypto_pkg::*;
    import asi_isa_pkg::*;
(
    input  wire   g_clk,
    input  wire   rst_n,                        // Synchronous, active low
    input  wire   asi_valid,
    input  wire   asi_req_t asi_req,
    output logic  asi_ready,                    // Instruction completes this cycle
    output word_t asi_result
);

    word_t      sha2_rs1;
    logic [1:0] sha2_ss;
    asi_req_t   sha3_req;
    logic       sub_valid;
    word_t      sub_rs1;
    word_t      sub_rs2;
    logic       sub_enc;
    logic       sub_rot;
    logic       sub_ready;
    word_t      mix_rs1;
    word_t      mix_rs2;
    logic       mix_enc;
    word_t      res_sha2;
    word_t      res_sha3;
    word_t      res_sub;
    word_t      res_mix;

    // Decode, gating and result select
    asi_ctrl i_asi_ctrl (
        .valid     (asi_valid),
        .req       (asi_req),
        .sub_ready (sub_ready),
        .res_sha2  (res_sha2),
        .res_sha3  (res_sha3),
        .res_sub   (res_sub),
        .res_mix   (res_mix),
        .sha2_rs1  (sha2_rs1),
        .sha2_ss   (sha2_ss),
        .sha3_req  (sha3_req),
        .sub_valid (sub_valid),
        .sub_rs1   (sub_rs1),
        .sub_rs2   (sub_rs2),
        .sub_enc   (sub_enc),
        .sub_rot   (sub_rot),
        .mix_rs1   (mix_rs1),
        .mix_rs2   (mix_rs2),
        .mix_enc   (mix_enc),
        .ready     (asi_ready),
        .result    (asi_result)
    );

    asi_sha256 i_asi_sha256 (
        .rs1    (sha2_rs1),
        .ss     (sha2_ss),
        .result (res_sha2)
    );

    asi_sha3 i_asi_sha3 (
        .req    (sha3_req),
        .result (res_sha3)
    );

    // Only sequential unit
    asi_aessub i_asi_aessub (
        .g_clk  (g_clk),
        .rst_n  (rst_n),
        .valid  (sub_valid),
        .rs1    (sub_rs1),
        .rs2    (sub_rs2),
        .enc    (sub_enc),
        .rot    (sub_rot),
        .ready  (sub_ready),
        .result (res_sub)
    );

    asi_aesmix i_asi_aesmix (
        .rs1    (mix_rs1),
        .rs2    (mix_rs2),
        .enc    (mix_enc),
        .result (res_mix)
    );

endmodule

`default_nettype wire

// ==== test/asi_model.svh ====
`ifndef ASI_MODEL_SVH
`define ASI_MODEL_SVH

// Reference S-box tables ------------------

byte_t fwd_tab [256];                           // Forward S-box
byte_t inv_tab [256];                           // Inverse S-box

// GF(2^8) product in Horner form, MSB first
function automatic byte_t field_mul(byte_t a, byte_t b);
    byte_t p;
    p = 8'h00;
    for (int i = 7; i >= 0; i--) begin
        p = {p[6:0], 1'b0} ^ (p[7] ? 8'h1b : 8'h00) ^ (b[i] ? a : 8'h00);
    end
    return p;
endfunction

// Inverse found by search, affine map applied bit by bit
task automatic build_sbox_tables();
    byte_t inv;
    byte_t s;
    for (int a = 0; a < 256; a++) begin
        inv = 8'h00;                            // Zero has no inverse
        for (int c = 1; c < 256; c++) begin
            if (field_mul(byte_t'(a), byte_t'(c)) == 8'h01) inv = byte_t'(c);
        end
        for (int i = 0; i < 8; i++) begin
            s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^
                   inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
        end
        s ^= 8'h63;
        fwd_tab[a] = s;
        inv_tab[s] = byte_t'(a);                // Bijection fills every entry
    end
endtask

// Per-unit references ------------------

function automatic word_t rotr(word_t x, int n);
    logic [63:0] d;
    d = {x, x} >> n;                            // Doubled word, low half is the rotate
    return d[31:0];
endfunction

function automatic word_t sigma_ref(logic [1:0] sel, word_t x);
    case (sel)
        2'd0:    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
        2'd1:    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
        2'd2:    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
        default: return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
    endcase
endfunction

// Keccak lane index, scaled by the post-shift
function automatic word_t lane_ref(logic [2:0] fn, word_t rs1, word_t rs2, logic [1:0] sh);
    int x;
    int y;
    int idx;
    x = int'(rs1 % 32'd5);
    y = int'(rs2 % 32'd5);
    case (fn)
        3'd0:    idx = x + 5 * y;
        3'd1:    idx = (x + 1) % 5 + 5 * y;
        3'd2:    idx = (x + 2) % 5 + 5 * y;
        3'd3:    idx = (x + 4) % 5 + 5 * y;
        default: idx = y + 5 * ((2 * x + 3 * y) % 5); // yx
    endcase
    return word_t'(idx * (1 << sh));
endfunction

// Mode bit 0 is decrypt, bit 1 is rotate
function automatic word_t subbytes_ref(logic [1:0] mode, word_t rs1, word_t rs2);
    word_t w;
    byte_t b;
    for (int i = 0; i < 4; i++) begin
        b = (i % 2 == 0) ? rs1[8*i +: 8] : rs2[8*i +: 8];
        w[8*i +: 8] = mode[0] ? inv_tab[b] : fwd_tab[b];
    end
    return mode[1] ? {w[23:0], w[31:24]} : w;
endfunction

// One output byte, column times a matrix row
function automatic byte_t dot4(word_t col, byte_t c0, byte_t c1, byte_t c2, byte_t c3);
    return field_mul(c0, col[7:0]) ^ field_mul(c1, col[15:8]) ^
           field_mul(c2, col[23:16]) ^ field_mul(c3, col[31:24]);
endfunction

function automatic word_t mixcol_ref(logic inverse, word_t rs1, word_t rs2);
    word_t col;
    col = {rs2[31:16], rs1[15:0]};
    if (inverse) begin
        return {dot4(col, 8'h0b, 8'h0d, 8'h09, 8'h0e), dot4(col, 8'h0d, 8'h09, 8'h0e, 8'h0b),
                dot4(col, 8'h09, 8'h0e, 8'h0b, 8'h0d), dot4(col, 8'h0e, 8'h0b, 8'h0d, 8'h09)};
    end
    return {dot4(col, 8'h03, 8'h01, 8'h01, 8'h02), dot4(col, 8'h01, 8'h01, 8'h02, 8'h03),
            dot4(col, 8'h01, 8'h02, 8'h03, 8'h01), dot4(col, 8'h02, 8'h03, 8'h01, 8'h01)};
endfunction

// Dispatch by class, AES split on the mix bit
function automatic word_t expected_result(asi_req_t req);
    case (req.uop[4:3])
        ASI_CLS_SHA2: return sigma_ref(req.uop[1:0], req.rs1);
        ASI_CLS_SHA3: return lane_ref(req.uop[2:0], req.rs1, req.rs2, req.shamt);
        default:      return req.uop[2] ? mixcol_ref(req.uop[0], req.rs1, req.rs2)
                                        : subbytes_ref(req.uop[1:0], req.rs1, req.rs2);
    endcase
endfunction

`endif

// ==== test/asi_tb.sv ====
`default_nettype none

module asi_tb
    import asi_crypto_pkg::*;
    import asi_isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N       = 200;               // Requests per test
    localparam int LIMIT   = 6 * N * 6 + 16;    // Six tests, six cycles a request, plus reset
    localparam int SETTLE  = 40;                // 10 ns before the rising edge
    localparam int SUB_LAT = 4;                 // SubBytes ready in its 4th valid cycle

    // Every micro-op grouped by unit
    localparam uop_t OPS [15] = '{ASI_SHA256_S0, ASI_SHA256_S1, ASI_SHA256_S2, ASI_SHA256_S3,
        ASI_SHA3_XY, ASI_SHA3_X1, ASI_SHA3_X2, ASI_SHA3_X4, ASI_SHA3_YX, ASI_AESSUB_ENC,
        ASI_AESSUB_ENCROT, ASI_AESSUB_DEC, ASI_AESSUB_DECROT, ASI_AESMIX_ENC, ASI_AESMIX_DEC};

    logic        g_clk     = 1'b0;
    logic        rst_n;
    logic        asi_valid;
    asi_req_t    asi_req;
    logic        asi_ready;
    word_t       asi_result;
    logic [31:0] lcg_state = 32'd26973;
    int          cycles    = 0;
    int          errs      = 0;                 // Errors in the running test
    int          passed    = 0;
    int          failed    = 0;
    string       cur_test  = "idle_after_reset";

    `include "asi_model.svh"

    asi_top dut_i (.g_clk, .rst_n, .asi_valid, .asi_req, .asi_ready, .asi_result);

    initial begin
        forever #50 g_clk = !g_clk;             // 100 ns period
    end

    // Monitors ------------------------------

    always @(posedge g_clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: the DUT hung, no ready within %0d cycles in %s", LIMIT, cur_test);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Ready without a held request
    always @(negedge g_clk) begin
        #SETTLE;
        assert (asi_valid || !asi_ready) else begin
            $display("Ready was high while valid was low in %s at cycle %0d", cur_test, cycles);
            errs++;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic close_test();
        @(negedge g_clk);
        asi_valid = 1'b0;
        @(posedge g_clk);                       // Let the monitor see the last cycle
        $display("%s: %0d errors", cur_test, errs);
        if (errs == 0) begin
            passed++;
        end else begin
            failed++;
        end
        errs = 0;
    endtask

    // Hold the request from a falling edge until ready, then check it
    task automatic issue(asi_req_t req, output word_t res);
        int   lat;
        int   want_lat;
        logic rdy;
        want_lat = (req.uop[4:3] == ASI_CLS_AES && !req.uop[2]) ? SUB_LAT : 1;
        @(negedge g_clk);
        asi_valid = 1'b1;
        asi_req   = req;
        lat = 0;
        rdy = 1'b0;
        while (!rdy) begin
            #SETTLE;
            lat++;                              // Counts valid cycles from 1
            rdy = asi_ready;
            res = asi_result;
            @(posedge g_clk);
            if (!rdy) @(negedge g_clk);
        end
        assert (res === expected_result(req)) else begin
            $display("Error %s expected %08h actual %08h", cur_test, expected_result(req), res);
            errs++;
        end
        assert (lat == want_lat) else begin
            $display("Error %s latency expected %0d actual %0d", cur_test, want_lat, lat);
            errs++;
        end
    endtask

    // Stimulus ------------------------------

    // A block of ops in turn, or any op at random when mixed
    task automatic sweep(string name, int first, int count, bit mixed);
        asi_req_t    req;
        word_t       res;
        logic [31:0] r;
        cur_test = name;
        for (int i = 0; i < N; i++) begin
            r = lcg_next();
            req.uop   = OPS[first + (mixed ? int'(r[31:16]) % count : i % count)];
            req.rs1   = lcg_next();
            req.rs2   = lcg_next();
            req.shamt = r[15:14];
            if (!mixed && r[13:12] == 2'b00) begin
                @(negedge g_clk);
                asi_valid = 1'b0;               // One idle cycle before the next request
            end
            issue(req, res);
        end
        close_test();
    endtask

    // InvMixColumns of a MixColumns result gives the column back
    task automatic mix_roundtrip();
        asi_req_t req;
        word_t    col;
        word_t    mixed;
        word_t    back;
        cur_test = "aes_mix";
        for (int i = 0; i < N; i++) begin
            req = '{uop: ASI_AESMIX_ENC, rs1: lcg_next(), rs2: lcg_next(), shamt: 2'b00};
            col = {req.rs2[31:16], req.rs1[15:0]};
            issue(req, mixed);
            req = '{uop: ASI_AESMIX_DEC, rs1: mixed, rs2: mixed, shamt: 2'b00};
            issue(req, back);
            assert (back === col) else begin
                $display("Error %s round trip expected %08h actual %08h", cur_test, col, back);
                errs++;
            end
        end
        close_test();
    endtask

    initial begin
        rst_n     = 1'b0;
        asi_valid = 1'b0;
        asi_req   = '0;
        build_sbox_tables();
        repeat (16) @(negedge g_clk);
        rst_n = 1'b1;
        repeat (20) @(posedge g_clk);           // Idle right after reset
        close_test();
        sweep("sha256", 0, 4, 1'b0);
        sweep("sha3_index", 4, 5, 1'b0);
        sweep("aes_sub", 9, 4, 1'b0);
        mix_roundtrip();
        sweep("mixed_stream", 0, 15, 1'b1);     // All classes back to back
        $display("Tests passed %0d, failed %0d", passed, failed);
        if (failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
